/* logic/floo_consts.svh */
`ifndef FLOO_CONSTS_SVH
`define FLOO_CONSTS_SVH

// Router ports, one per mesh direction plus the local port
`define FLOO_NUM_PORTS 5

// Input FIFO slots, also the initial credit count of every link
`define FLOO_FIFO_DEPTH 2

// Width of one mesh coordinate
`define FLOO_COORD_W 2

// Payload widths of the two physical networks
`define FLOO_NARROW_W 32
`define FLOO_WIDE_W 128

`endif

/* logic/floo_route_pkg.sv */
`default_nettype none

`include "floo_consts.svh"

package floo_route_pkg;

  // Output direction, also used as the port index
  typedef enum logic [2:0] {
    DIR_NORTH = 3'd0,
    DIR_EAST  = 3'd1,
    DIR_SOUTH = 3'd2,
    DIR_WEST  = 3'd3,
    DIR_LOCAL = 3'd4
  } route_dir_e;

  // Position of a router in the mesh
  typedef struct packed {
    logic [`FLOO_COORD_W-1:0] x;
    logic [`FLOO_COORD_W-1:0] y;
  } xy_id_t;

endpackage

`default_nettype wire

/* logic/floo_flit_pkg.sv */
`default_nettype none

`include "floo_consts.svh"

package floo_flit_pkg;

  import floo_route_pkg::*;

  typedef struct packed {
    xy_id_t dst;
  } hdr_t;

  // Both flits lead with the header so routing is network agnostic
  typedef struct packed {
    hdr_t                      hdr;
    logic [`FLOO_NARROW_W-1:0] payload;
  } narrow_flit_t;

  typedef struct packed {
    hdr_t                    hdr;
    logic [`FLOO_WIDE_W-1:0] payload;
  } wide_flit_t;

endpackage

`default_nettype wire

/* logic/floo_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface floo_port_if
  import floo_route_pkg::*;
#(
  parameter type flit_t = logic
) ();

  logic       valid;
  flit_t      flit;
  route_dir_e out_dir;
  // Head leaves the FIFO this cycle
  logic       grant;

  modport port (output valid, output flit, output out_dir, input grant);
  modport switch (input valid, input flit, input out_dir, output grant);

endinterface

`default_nettype wire

/* logic/floo_input_port.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floo_consts.svh"

module floo_input_port
  import floo_route_pkg::*;
  import floo_flit_pkg::*;
#(
  parameter type flit_t = narrow_flit_t
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  xy_id_t       xy_id_i,
  input  logic         valid_i,
  input  flit_t        flit_i,
  output logic         credit_o,
  floo_port_if.port    head
);

  localparam int ptr_w = (`FLOO_FIFO_DEPTH > 1) ? $clog2(`FLOO_FIFO_DEPTH) : 1;
  localparam int cnt_w = $clog2(`FLOO_FIFO_DEPTH + 1);

  logic             in_valid_q;
  flit_t            in_flit_q;
  flit_t            mem [`FLOO_FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             pop;
  flit_t            head_flit;
  xy_id_t           dst;
  route_dir_e       route;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(`FLOO_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign pop       = head.grant;
  assign head_flit = mem[rd_ptr_q];
  assign dst       = head_flit.hdr.dst;

  // Dimension ordered, X first then Y
  always_comb begin
    if (dst.x > xy_id_i.x) begin
      route = DIR_EAST;
    end else if (dst.x < xy_id_i.x) begin
      route = DIR_WEST;
    end else if (dst.y > xy_id_i.y) begin
      route = DIR_NORTH;
    end else if (dst.y < xy_id_i.y) begin
      route = DIR_SOUTH;
    end else begin
      route = DIR_LOCAL;
    end
  end

  assign head.valid   = (count_q != '0);
  assign head.flit    = head_flit;
  assign head.out_dir = route;

  // Link flit is captured first and enters the FIFO one edge later
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      in_flit_q <= flit_i;
    end
    if (in_valid_q) begin
      mem[wr_ptr_q] <= in_flit_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_valid_q <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      credit_o   <= 1'b0;
    end else begin
      in_valid_q <= valid_i;
      credit_o   <= pop;
      if (in_valid_q) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({in_valid_q, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/floo_switch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floo_consts.svh"

module floo_switch
  import floo_route_pkg::*;
#(
  parameter type flit_t = logic
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  floo_port_if.switch                       heads [`FLOO_NUM_PORTS],
  output logic         [`FLOO_NUM_PORTS-1:0] valid_o,
  output flit_t        [`FLOO_NUM_PORTS-1:0] flit_o,
  input  logic         [`FLOO_NUM_PORTS-1:0] credit_i
);

  localparam int num_ports = `FLOO_NUM_PORTS;
  localparam int port_w    = $clog2(num_ports);
  localparam int cnt_w     = $clog2(`FLOO_FIFO_DEPTH + 1);

  logic [num_ports-1:0]  in_valid;
  flit_t [num_ports-1:0] in_flit;
  route_dir_e            in_dir [num_ports];
  logic [num_ports-1:0]  in_grant;

  logic [num_ports-1:0]  win_valid;
  logic [port_w-1:0]     win_idx [num_ports];
  logic [port_w-1:0]     rr_ptr_q [num_ports];
  logic [cnt_w-1:0]      cnt_q [num_ports];

  function automatic logic [port_w-1:0] next_port(input logic [port_w-1:0] idx);
    if (idx == port_w'(num_ports - 1)) begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

  for (genvar i = 0; i < num_ports; i++) begin : gen_heads
    assign in_valid[i]    = heads[i].valid;
    assign in_flit[i]     = heads[i].flit;
    assign in_dir[i]      = heads[i].out_dir;
    assign heads[i].grant = in_grant[i];
  end

  // Round robin search from the pointer, gated by downstream credit
  always_comb begin
    int idx;
    win_valid = '0;
    in_grant  = '0;
    for (int o = 0; o < num_ports; o++) begin
      win_idx[o] = '0;
      for (int k = 0; k < num_ports; k++) begin
        idx = (int'(rr_ptr_q[o]) + k) % num_ports;
        if (!win_valid[o] && (cnt_q[o] != '0) && in_valid[idx] &&
            (in_dir[idx] == route_dir_e'(o))) begin
          win_valid[o] = 1'b1;
          win_idx[o]   = port_w'(idx);
        end
      end
      // Each input requests a single output, so at most one grant per input
      if (win_valid[o]) begin
        in_grant[win_idx[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < num_ports; o++) begin
      if (win_valid[o]) begin
        flit_o[o] <= in_flit[win_idx[o]];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= '0;
      for (int o = 0; o < num_ports; o++) begin
        rr_ptr_q[o] <= '0;
        cnt_q[o]    <= cnt_w'(`FLOO_FIFO_DEPTH);
      end
    end else begin
      valid_o <= win_valid;
      for (int o = 0; o < num_ports; o++) begin
        if (win_valid[o]) begin
          rr_ptr_q[o] <= next_port(win_idx[o]);
        end
        // Send and returned credit in one cycle cancel out
        if (win_valid[o] && !credit_i[o]) begin
          cnt_q[o] <= cnt_q[o] - 1'b1;
        end else if (!win_valid[o] && credit_i[o]) begin
          cnt_q[o] <= cnt_q[o] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/floo_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floo_consts.svh"

module floo_router
  import floo_route_pkg::*;
  import floo_flit_pkg::*;
#(
  parameter type flit_t = narrow_flit_t
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  xy_id_t                      xy_id_i,
  input  logic  [`FLOO_NUM_PORTS-1:0] valid_i,
  input  flit_t [`FLOO_NUM_PORTS-1:0] flit_i,
  output logic  [`FLOO_NUM_PORTS-1:0] credit_o,
  output logic  [`FLOO_NUM_PORTS-1:0] valid_o,
  output flit_t [`FLOO_NUM_PORTS-1:0] flit_o,
  input  logic  [`FLOO_NUM_PORTS-1:0] credit_i
);

  floo_port_if #(.flit_t(flit_t)) heads [`FLOO_NUM_PORTS] ();

  for (genvar i = 0; i < `FLOO_NUM_PORTS; i++) begin : gen_in_ports
    floo_input_port #(
      .flit_t (flit_t)
    ) i_input_port (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .xy_id_i  (xy_id_i),
      .valid_i  (valid_i[i]),
      .flit_i   (flit_i[i]),
      .credit_o (credit_o[i]),
      .head     (heads[i])
    );
  end

  floo_switch #(
    .flit_t (flit_t)
  ) i_switch (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .heads    (heads),
    .valid_o  (valid_o),
    .flit_o   (flit_o),
    .credit_i (credit_i)
  );

endmodule

`default_nettype wire

/* logic/floo_narrow_wide_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floo_consts.svh"

module floo_narrow_wide_router
  import floo_route_pkg::*;
  import floo_flit_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  xy_id_t                             xy_id_i,

  input  logic         [`FLOO_NUM_PORTS-1:0] narrow_valid_i,
  input  narrow_flit_t [`FLOO_NUM_PORTS-1:0] narrow_flit_i,
  output logic         [`FLOO_NUM_PORTS-1:0] narrow_credit_o,
  output logic         [`FLOO_NUM_PORTS-1:0] narrow_valid_o,
  output narrow_flit_t [`FLOO_NUM_PORTS-1:0] narrow_flit_o,
  input  logic         [`FLOO_NUM_PORTS-1:0] narrow_credit_i,

  input  logic         [`FLOO_NUM_PORTS-1:0] wide_valid_i,
  input  wide_flit_t   [`FLOO_NUM_PORTS-1:0] wide_flit_i,
  output logic         [`FLOO_NUM_PORTS-1:0] wide_credit_o,
  output logic         [`FLOO_NUM_PORTS-1:0] wide_valid_o,
  output wide_flit_t   [`FLOO_NUM_PORTS-1:0] wide_flit_o,
  input  logic         [`FLOO_NUM_PORTS-1:0] wide_credit_i
);

  // Same router on both networks, only the flit type differs
  floo_router #(
    .flit_t (narrow_flit_t)
  ) i_narrow_router (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .xy_id_i  (xy_id_i),
    .valid_i  (narrow_valid_i),
    .flit_i   (narrow_flit_i),
    .credit_o (narrow_credit_o),
    .valid_o  (narrow_valid_o),
    .flit_o   (narrow_flit_o),
    .credit_i (narrow_credit_i)
  );

  floo_router #(
    .flit_t (wide_flit_t)
  ) i_wide_router (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .xy_id_i  (xy_id_i),
    .valid_i  (wide_valid_i),
    .flit_i   (wide_flit_i),
    .credit_o (wide_credit_o),
    .valid_o  (wide_valid_o),
    .flit_o   (wide_flit_o),
    .credit_i (wide_credit_i)
  );

endmodule

`default_nettype wire

/* verification/floo_router_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "floo_consts.svh"

module floo_router_tb
  import floo_route_pkg::*;
  import floo_flit_pkg::*;
();

  localparam int num_ports = `FLOO_NUM_PORTS;
  localparam int depth     = `FLOO_FIFO_DEPTH;
  localparam int timeout   = 200;
  localparam int stim_len  = 64;

  localparam logic [3:0] op_send    = 4'h1;
  localparam logic [3:0] op_block   = 4'h2;
  localparam logic [3:0] op_release = 4'h3;
  localparam logic [3:0] op_drain   = 4'h4;
  localparam logic [3:0] op_end     = 4'hf;

  logic   clk = 1'b0;
  logic   rst_n;
  xy_id_t xy_id;

  logic         [num_ports-1:0] narrow_valid_i;
  narrow_flit_t [num_ports-1:0] narrow_flit_i;
  logic         [num_ports-1:0] narrow_credit_o;
  logic         [num_ports-1:0] narrow_valid_o;
  narrow_flit_t [num_ports-1:0] narrow_flit_o;
  logic         [num_ports-1:0] narrow_credit_i;
  logic         [num_ports-1:0] wide_valid_i;
  wide_flit_t   [num_ports-1:0] wide_flit_i;
  logic         [num_ports-1:0] wide_credit_o;
  logic         [num_ports-1:0] wide_valid_o;
  wide_flit_t   [num_ports-1:0] wide_flit_o;
  logic         [num_ports-1:0] wide_credit_i;

  logic [63:0]  stim [stim_len];
  // Scoreboard per network and output port
  logic [131:0] exp_q [2][num_ports][$];
  int           sent_edge_q [2][num_ports][$];
  bit           lat_chk_q [2][num_ports][$];
  int           up_credits [2][num_ports];
  int           cred_edge [2][num_ports];
  int           owed [2][num_ports];
  bit           blocked [2][num_ports];
  int           delivered [2][num_ports];
  int           cyc;

  floo_narrow_wide_router u_dut (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .xy_id_i         (xy_id),
    .narrow_valid_i  (narrow_valid_i),
    .narrow_flit_i   (narrow_flit_i),
    .narrow_credit_o (narrow_credit_o),
    .narrow_valid_o  (narrow_valid_o),
    .narrow_flit_o   (narrow_flit_o),
    .narrow_credit_i (narrow_credit_i),
    .wide_valid_i    (wide_valid_i),
    .wide_flit_i     (wide_flit_i),
    .wide_credit_o   (wide_credit_o),
    .wide_valid_o    (wide_valid_o),
    .wide_flit_o     (wide_flit_o),
    .wide_credit_i   (wide_credit_i)
  );

  always #2 clk = ~clk;

  task automatic stop_on_failure();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [131:0] got,
                             input logic [131:0] exp);
    if (got !== exp) begin
      $display("mismatch %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // Wide payload spread out from the 32-bit stimulus value
  function automatic logic [127:0] widen(input logic [31:0] p);
    return {~p, p ^ 32'h5a5a5a5a, {p[15:0], p[31:16]}, p};
  endfunction

  function automatic bit all_idle();
    for (int n = 0; n < 2; n++) begin
      for (int o = 0; o < num_ports; o++) begin
        if (exp_q[n][o].size() != 0 || owed[n][o] != 0) begin
          return 1'b0;
        end
      end
    end
    return 1'b1;
  endfunction

  task automatic step();
    @(negedge clk);
    narrow_valid_i = '0;
    wide_valid_i   = '0;
  endtask

  task automatic send_flit(input int n, input int p, input logic [1:0] dx, input logic [1:0] dy,
                           input int expo, input bit same, input bit latc,
                           input logic [31:0] pay);
    int waited;
    logic [127:0] wpay;
    waited = 0;
    while (up_credits[n][p] == 0) begin
      if (waited == timeout) begin
        $display("timeout waiting for an upstream credit on input %0d", p);
        stop_on_failure();
      end
      step();
      waited++;
    end
    wpay = widen(pay);
    if (n == 0) begin
      narrow_valid_i[p] = 1'b1;
      narrow_flit_i[p]  = {dx, dy, pay};
      exp_q[n][expo].push_back({96'b0, dx, dy, pay});
    end else begin
      wide_valid_i[p] = 1'b1;
      wide_flit_i[p]  = {dx, dy, wpay};
      exp_q[n][expo].push_back({dx, dy, wpay});
    end
    up_credits[n][p]--;
    sent_edge_q[n][expo].push_back(cyc + 1);
    lat_chk_q[n][expo].push_back(latc);
    if (latc) begin
      cred_edge[n][p] = cyc + 1;
    end
    if (!same) begin
      step();
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!all_idle()) begin
      if (waited == timeout) begin
        $display("timeout waiting for all outputs to drain");
        stop_on_failure();
      end
      step();
      waited++;
    end
  endtask

  // Outputs and credit pulses sampled at the edge, before it updates them
  always @(posedge clk) begin
    logic [131:0] got;
    logic         v;
    logic         c;
    int           lat;
    cyc = cyc + 1;
    if (rst_n) begin
      for (int n = 0; n < 2; n++) begin
        for (int o = 0; o < num_ports; o++) begin
          got = '0;
          if (n == 0) begin
            v = narrow_valid_o[o];
            c = narrow_credit_o[o];
            got[35:0] = narrow_flit_o[o];
          end else begin
            v = wide_valid_o[o];
            c = wide_credit_o[o];
            got = wide_flit_o[o];
          end
          if (v) begin
            if (exp_q[n][o].size() == 0) begin
              $display("unexpected flit on output %0d of network %0d", o, n);
              stop_on_failure();
            end
            check_value(n == 0 ? "narrow_flit_o" : "wide_flit_o", got,
                        exp_q[n][o].pop_front());
            lat = (cyc - 1) - sent_edge_q[n][o].pop_front();
            if (lat_chk_q[n][o].pop_front()) begin
              check_value("flit_latency", 132'(lat), 132'(2));
            end
            delivered[n][o]++;
            owed[n][o]++;
          end
          if (c) begin
            up_credits[n][o]++;
            // Pop at t+2, pulse in the cycle that follows
            if (cred_edge[n][o] >= 0) begin
              check_value("credit_edge", 132'(cyc - 1), 132'(cred_edge[n][o] + 2));
              cred_edge[n][o] = -1;
            end
            if (up_credits[n][o] > depth) begin
              $display("more credits returned than flits sent on input %0d", o);
              stop_on_failure();
            end
          end
        end
      end
    end
  end

  // Return credits to the DUT outputs unless held back
  always @(negedge clk) begin
    for (int n = 0; n < 2; n++) begin
      for (int o = 0; o < num_ports; o++) begin
        if (rst_n && !blocked[n][o] && owed[n][o] > 0) begin
          owed[n][o]--;
          if (n == 0) narrow_credit_i[o] = 1'b1;
          else wide_credit_i[o] = 1'b1;
        end else begin
          if (n == 0) narrow_credit_i[o] = 1'b0;
          else wide_credit_i[o] = 1'b0;
        end
      end
    end
  end

  initial begin
    repeat (20000) @(posedge clk);
    $display("simulation ran past its overall time limit");
    stop_on_failure();
  end

  initial begin
    logic [63:0] line;
    int          idx;
    int          n;
    int          p;
    int          out_port;
    bit          running;
    cyc             = 0;
    rst_n           = 1'b0;
    xy_id           = '{x: 2'd1, y: 2'd1};
    narrow_valid_i  = '0;
    narrow_flit_i   = '0;
    narrow_credit_i = '0;
    wide_valid_i    = '0;
    wide_flit_i     = '0;
    wide_credit_i   = '0;
    for (int i = 0; i < 2; i++) begin
      for (int o = 0; o < num_ports; o++) begin
        up_credits[i][o] = depth;
        cred_edge[i][o]  = -1;
        owed[i][o]       = 0;
        blocked[i][o]    = 1'b0;
        delivered[i][o]  = 0;
      end
    end
    $readmemh("verification/router_stimulus.mem", stim);
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n   = 1'b1;
    idx     = 0;
    running = 1'b1;
    while (running) begin
      if (idx >= stim_len) begin
        $display("stimulus ended without an end operation");
        stop_on_failure();
      end
      line = stim[idx];
      idx++;
      n = int'(line[59:56]);
      p = int'(line[55:52]);
      // Block and release name their output in the dst_x column
      out_port = int'(line[51:48]);
      case (line[63:60])
        op_send: send_flit(n, p, line[49:48], line[45:44], int'(line[43:40]), line[36],
                           line[32], line[31:0]);
        op_block: begin
          blocked[n][out_port]   = 1'b1;
          delivered[n][out_port] = 0;
          step();
        end
        op_release: begin
          repeat (20) step();
          check_value("blocked_deliveries", 132'(delivered[n][out_port]), 132'(depth));
          blocked[n][out_port] = 1'b0;
          step();
        end
        op_drain: wait_drain();
        op_end: running = 1'b0;
        default: begin
          $display("unknown operation in stimulus line %0d", idx - 1);
          stop_on_failure();
        end
      endcase
    end
    wait_drain();
    for (int i = 0; i < 2; i++) begin
      for (int o = 0; o < num_ports; o++) begin
        check_value("up_credits", 132'(up_credits[i][o]), 132'(depth));
      end
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/router_stimulus.mem */
// op net in_port dst_x dst_y exp_port same_cycle check_latency payload[31:0]
// op 1 send, 2 block output, 3 release output, 4 drain, f end
10421101A0000001
10312001A0000002
10201301A0000003
10110201A0000004
10011401A0000005
11421101B0000001
11312001B0000002
11201301B0000003
11110201B0000004
11011401B0000005
4000000000000000
10111410C0000001
10211410C0000002
10311410C0000003
10011400C0000004
10111400C0000005
4000000000000000
2001000000000000
10321100D0000001
10321100D0000002
10321100D0000003
10321100D0000004
3001000000000000
4000000000000000
10021110E0000001
11021110E0000002
10211410E0000003
11401300E0000004
10312000E0000005
11110200E0000006
4000000000000000
F000000000000000

/* floo_router.f */
+incdir+logic
logic/floo_route_pkg.sv
logic/floo_flit_pkg.sv
logic/floo_port_if.sv
logic/floo_input_port.sv
logic/floo_switch.sv
logic/floo_router.sv
logic/floo_narrow_wide_router.sv
verification/floo_router_tb.sv

/* Makefile */
SRCS := $(wildcard logic/*.sv logic/*.svh verification/*.sv)
BIN := obj_dir/Vfloo_router_tb

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "sim passed"

$(BIN): $(SRCS) floo_router.f
	verilator --binary -j 0 --top-module floo_router_tb -f floo_router.f

clean:
	rm -rf obj_dir
